//--- Makefile
VERILATOR = verilator
TOP       = xdom_core_tb
FILELIST  = xdom_core.f
OBJ_DIR   = obj_dir
VFLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)
RUNFLAGS  = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- chan_stat_sel.sv
// per-channel status selector
//   select register written over the register bus
//   registered readback of the selected channel, zero when out of range

`timescale 1ns/1ps

module chan_stat_sel #(
  parameter type                        payload_t = xdom_pkg::wds_word_t,
  parameter logic [xdom_pkg::ADR_W-1:0] SEL_ADR   = xdom_pkg::ADR_STAT_SEL
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  payload_t [xdom_pkg::N_CHANNELS-1:0]   i_chan_vals,
  output logic [xdom_pkg::CHAN_SEL_W-1:0]       o_sel,
  output payload_t                              o_val,
  crs_bus_if.monitor                            bus
);

  always_ff @(posedge clk) begin
    if (rst) begin
      o_sel <= '0;
    end else if (bus.wr && (bus.adr == SEL_ADR)) begin
      o_sel <= bus.wr_data[xdom_pkg::CHAN_SEL_W-1:0];
    end
  end

  // sampled every cycle
  always_ff @(posedge clk) begin
    o_val <= (o_sel < xdom_pkg::N_CHANNELS) ? i_chan_vals[o_sel] : '0;
  end

endmodule

//--- crs_arbiter.sv
// round-robin arbiter of two host command ports onto the register bus
//   grant, bus cycle, then acknowledge with captured read data
//   priority override port takes the bus when no grant is in flight

`timescale 1ns/1ps

module crs_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_h0_wr_req,
  input  logic                        i_h0_rd_req,
  input  logic [xdom_pkg::ADR_W-1:0]  i_h0_adr,
  input  logic [xdom_pkg::DATA_W-1:0] i_h0_wr_data,
  input  logic                        i_h1_wr_req,
  input  logic                        i_h1_rd_req,
  input  logic [xdom_pkg::ADR_W-1:0]  i_h1_adr,
  input  logic [xdom_pkg::DATA_W-1:0] i_h1_wr_data,
  input  logic                        i_po_en,
  input  logic                        i_po_wr,
  input  logic [xdom_pkg::ADR_W-1:0]  i_po_adr,
  input  logic [xdom_pkg::DATA_W-1:0] i_po_wr_data,
  output logic                        o_h0_ack,
  output logic                        o_h1_ack,
  output logic [xdom_pkg::DATA_W-1:0] o_h0_rd_data,
  output logic [xdom_pkg::DATA_W-1:0] o_h1_rd_data,
  output logic [xdom_pkg::DATA_W-1:0] o_po_rd_data,
  crs_bus_if.arbiter                  bus
);

  typedef enum logic [1:0] {ST_IDLE, ST_GNT, ST_ACK} state_t;

  state_t                      state;
  logic                        last_h1;
  logic                        wr_q;
  logic [xdom_pkg::ADR_W-1:0]  adr_q;
  logic [xdom_pkg::DATA_W-1:0] wr_data_q;
  logic [xdom_pkg::DATA_W-1:0] rd_data_q;
  logic                        h0_req;
  logic                        h1_req;
  logic                        pick_h1;
  logic                        grant;
  logic                        po_sel;

  assign h0_req = i_h0_wr_req | i_h0_rd_req;
  assign h1_req = i_h1_wr_req | i_h1_rd_req;

  // on a tie the host not granted last wins
  assign pick_h1 = h1_req && (!h0_req || !last_h1);
  assign grant   = (state == ST_IDLE) && !i_po_en && (h0_req || h1_req);
  assign po_sel  = i_po_en && (state == ST_IDLE);

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      last_h1  <= 1'b0;
      wr_q     <= 1'b0;
      o_h0_ack <= 1'b0;
      o_h1_ack <= 1'b0;
    end else begin
      wr_q     <= 1'b0;
      o_h0_ack <= 1'b0;
      o_h1_ack <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (grant) begin
            state   <= ST_GNT;
            last_h1 <= pick_h1;
            wr_q    <= pick_h1 ? i_h1_wr_req : i_h0_wr_req;
          end
        end
        ST_GNT: begin
          state    <= ST_ACK;
          o_h0_ack <= !last_h1;
          o_h1_ack <= last_h1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // winner's address and data, read data at the end of the bus cycle
  always_ff @(posedge clk) begin
    if (grant) begin
      adr_q     <= pick_h1 ? i_h1_adr : i_h0_adr;
      wr_data_q <= pick_h1 ? i_h1_wr_data : i_h0_wr_data;
    end
    if (state == ST_GNT) begin
      rd_data_q <= bus.rd_data;
    end
  end

  assign bus.adr     = po_sel ? i_po_adr : adr_q;
  assign bus.wr_data = po_sel ? i_po_wr_data : wr_data_q;
  assign bus.wr      = po_sel ? i_po_wr : wr_q;

  assign o_h0_rd_data = rd_data_q;
  assign o_h1_rd_data = rd_data_q;
  assign o_po_rd_data = bus.rd_data;

endmodule

//--- crs_bus_if.sv
// shared register bus between the host arbiter and the register blocks
//   arbiter, target and monitor modports

`timescale 1ns/1ps

interface crs_bus_if;

  logic [xdom_pkg::ADR_W-1:0]  adr;
  logic [xdom_pkg::DATA_W-1:0] wr_data;
  // one-cycle write strobe
  logic                        wr;
  // combinational from adr
  logic [xdom_pkg::DATA_W-1:0] rd_data;

  modport arbiter (output adr, output wr_data, output wr, input rd_data);

  modport target (input adr, input wr_data, input wr, output rd_data);

  // write decode only
  modport monitor (input adr, input wr_data, input wr);

endinterface

//--- spi_task_reg.sv
// ADC SPI task register
//   request level held until the SPI engine acknowledges
//   24-bit write-data word in two halves

`timescale 1ns/1ps

module spi_task_reg (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            i_adc_spi_ack,
  output logic                            o_adc_spi_req,
  output logic                            o_task_val,
  output logic [xdom_pkg::SPI_DATA_W-1:0] o_adc_spi_wr_data,
  crs_bus_if.monitor                      bus
);

  logic task_wr;

  assign task_wr = bus.wr && (bus.adr == xdom_pkg::ADR_ADC_SPI_TASK) && bus.wr_data[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_adc_spi_req     <= 1'b0;
      o_adc_spi_wr_data <= '0;
    end else begin
      // ack wins over a new task write
      if (i_adc_spi_ack) begin
        o_adc_spi_req <= 1'b0;
      end else if (task_wr) begin
        o_adc_spi_req <= 1'b1;
      end
      if (bus.wr && (bus.adr == xdom_pkg::ADR_ADC_SPI_HI)) begin
        o_adc_spi_wr_data[xdom_pkg::SPI_DATA_W-1:xdom_pkg::DATA_W] <=
          bus.wr_data[xdom_pkg::SPI_DATA_W-xdom_pkg::DATA_W-1:0];
      end
      if (bus.wr && (bus.adr == xdom_pkg::ADR_ADC_SPI_LO)) begin
        o_adc_spi_wr_data[xdom_pkg::DATA_W-1:0] <= bus.wr_data;
      end
    end
  end

  // busy while requested or still acknowledging
  assign o_task_val = o_adc_spi_req | i_adc_spi_ack;

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset
//   4 ns clock, reset held for the first 8 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst
);

  localparam int RST_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // released just after an edge, like every other input
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #1;
    o_rst = 1'b0;
  end

endmodule

//--- trig_ctrl_regs.sv
// trigger configuration registers and software trigger pulse
//   mode bits, threshold, 24-channel software mask
//   read mux of the whole register bus

`timescale 1ns/1ps

module trig_ctrl_regs (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [xdom_pkg::DATA_W-1:0]          i_vnum,
  input  logic                                 i_adc_spi_task_val,
  input  logic [xdom_pkg::SPI_DATA_W-1:0]      i_adc_spi_wr_data,
  input  xdom_pkg::wds_word_t                  i_wds_used,
  input  xdom_pkg::scaler_word_t               i_scaler,
  input  logic [xdom_pkg::CHAN_SEL_W-1:0]      i_stat_sel,
  input  logic [xdom_pkg::CHAN_SEL_W-1:0]      i_scaler_sel,
  output xdom_pkg::trig_ctrl_t                 o_trig_ctrl,
  output logic [xdom_pkg::THR_W-1:0]           o_trig_thr,
  output logic [xdom_pkg::N_CHANNELS-1:0]      o_trig_run,
  crs_bus_if.target                            bus
);

  logic [xdom_pkg::N_CHANNELS-1:0] sw_mask;

  ////////////////////
  // write side
  always_ff @(posedge clk) begin
    if (rst) begin
      o_trig_ctrl <= '0;
      o_trig_thr  <= '0;
      sw_mask     <= '0;
      o_trig_run  <= '0;
    end else begin
      // pulse clears itself
      o_trig_run <= '0;
      if (bus.wr) begin
        case (bus.adr)
          xdom_pkg::ADR_TRIG_CTRL: begin
            o_trig_ctrl <= xdom_pkg::trig_ctrl_t'({9'b0, bus.wr_data[6:0]});
          end
          xdom_pkg::ADR_TRIG_THR: begin
            o_trig_thr <= bus.wr_data[xdom_pkg::THR_W-1:0];
          end
          xdom_pkg::ADR_SW_MASK_HI: begin
            sw_mask[xdom_pkg::N_CHANNELS-1:xdom_pkg::DATA_W] <=
              bus.wr_data[xdom_pkg::N_CHANNELS-xdom_pkg::DATA_W-1:0];
          end
          xdom_pkg::ADR_SW_MASK_LO: begin
            sw_mask[xdom_pkg::DATA_W-1:0] <= bus.wr_data;
          end
          xdom_pkg::ADR_TRIG_PULSE: begin
            if (bus.wr_data[0]) begin
              o_trig_run <= sw_mask;
            end
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////
  // read mux, unmapped reads are zero
  always_comb begin
    bus.rd_data = '0;
    case (bus.adr)
      xdom_pkg::ADR_VNUM:       bus.rd_data = i_vnum;
      xdom_pkg::ADR_TRIG_CTRL:  bus.rd_data = o_trig_ctrl;
      xdom_pkg::ADR_TRIG_THR:   bus.rd_data[xdom_pkg::THR_W-1:0] = o_trig_thr;
      xdom_pkg::ADR_SW_MASK_HI: begin
        bus.rd_data[xdom_pkg::N_CHANNELS-xdom_pkg::DATA_W-1:0] =
          sw_mask[xdom_pkg::N_CHANNELS-1:xdom_pkg::DATA_W];
      end
      xdom_pkg::ADR_SW_MASK_LO:   bus.rd_data = sw_mask[xdom_pkg::DATA_W-1:0];
      xdom_pkg::ADR_ADC_SPI_TASK: bus.rd_data[0] = i_adc_spi_task_val;
      xdom_pkg::ADR_ADC_SPI_HI: begin
        bus.rd_data[xdom_pkg::SPI_DATA_W-xdom_pkg::DATA_W-1:0] =
          i_adc_spi_wr_data[xdom_pkg::SPI_DATA_W-1:xdom_pkg::DATA_W];
      end
      xdom_pkg::ADR_ADC_SPI_LO: bus.rd_data = i_adc_spi_wr_data[xdom_pkg::DATA_W-1:0];
      xdom_pkg::ADR_STAT_SEL:   bus.rd_data[xdom_pkg::CHAN_SEL_W-1:0] = i_stat_sel;
      xdom_pkg::ADR_WDS_USED:   bus.rd_data = i_wds_used;
      xdom_pkg::ADR_SCALER_SEL: bus.rd_data[xdom_pkg::CHAN_SEL_W-1:0] = i_scaler_sel;
      xdom_pkg::ADR_SCALER_HI:  bus.rd_data = i_scaler[2*xdom_pkg::DATA_W-1:xdom_pkg::DATA_W];
      xdom_pkg::ADR_SCALER_LO:  bus.rd_data = i_scaler[xdom_pkg::DATA_W-1:0];
      default: ;
    endcase
  end

endmodule

//--- xdom_core.f
xdom_pkg.sv
crs_bus_if.sv
crs_arbiter.sv
trig_ctrl_regs.sv
spi_task_reg.sv
chan_stat_sel.sv
xdom_core.sv
tb_clk_gen.sv
xdom_core_checker.sv
xdom_core_tb.sv

//--- xdom_core.sv
// command, response and status hub, top level
//   register bus with arbiter, trigger registers, ADC SPI task
//   words-used and scaler channel selectors

`timescale 1ns/1ps

module xdom_core (
  input  logic                                          clk,
  input  logic                                          rst,
  // debug host
  input  logic                                          i_h0_wr_req,
  input  logic                                          i_h0_rd_req,
  input  logic [xdom_pkg::ADR_W-1:0]                    i_h0_adr,
  input  logic [xdom_pkg::DATA_W-1:0]                   i_h0_wr_data,
  output logic                                          o_h0_ack,
  output logic [xdom_pkg::DATA_W-1:0]                   o_h0_rd_data,
  // ICM host
  input  logic                                          i_h1_wr_req,
  input  logic                                          i_h1_rd_req,
  input  logic [xdom_pkg::ADR_W-1:0]                    i_h1_adr,
  input  logic [xdom_pkg::DATA_W-1:0]                   i_h1_wr_data,
  output logic                                          o_h1_ack,
  output logic [xdom_pkg::DATA_W-1:0]                   o_h1_rd_data,
  // priority override
  input  logic                                          i_po_en,
  input  logic                                          i_po_wr,
  input  logic [xdom_pkg::ADR_W-1:0]                    i_po_adr,
  input  logic [xdom_pkg::DATA_W-1:0]                   i_po_wr_data,
  output logic [xdom_pkg::DATA_W-1:0]                   o_po_rd_data,
  input  logic [xdom_pkg::DATA_W-1:0]                   i_vnum,
  // trigger
  output xdom_pkg::trig_ctrl_t                          o_trig_ctrl,
  output logic [xdom_pkg::THR_W-1:0]                    o_trig_thr,
  output logic [xdom_pkg::N_CHANNELS-1:0]               o_trig_run,
  // ADC SPI
  output logic                                          o_adc_spi_req,
  input  logic                                          i_adc_spi_ack,
  output logic [xdom_pkg::SPI_DATA_W-1:0]               o_adc_spi_wr_data,
  // per-channel status
  input  xdom_pkg::wds_word_t [xdom_pkg::N_CHANNELS-1:0]    i_buf_wds_used,
  input  xdom_pkg::scaler_word_t [xdom_pkg::N_CHANNELS-1:0] i_disc_scaler
);

  logic                            adc_spi_task_val;
  logic [xdom_pkg::CHAN_SEL_W-1:0] stat_sel;
  logic [xdom_pkg::CHAN_SEL_W-1:0] scaler_sel;
  xdom_pkg::wds_word_t             wds_used_val;
  xdom_pkg::scaler_word_t          scaler_val;

  crs_bus_if bus ();

  crs_arbiter arb0 (
    .clk          (clk),
    .rst          (rst),
    .i_h0_wr_req  (i_h0_wr_req),
    .i_h0_rd_req  (i_h0_rd_req),
    .i_h0_adr     (i_h0_adr),
    .i_h0_wr_data (i_h0_wr_data),
    .i_h1_wr_req  (i_h1_wr_req),
    .i_h1_rd_req  (i_h1_rd_req),
    .i_h1_adr     (i_h1_adr),
    .i_h1_wr_data (i_h1_wr_data),
    .i_po_en      (i_po_en),
    .i_po_wr      (i_po_wr),
    .i_po_adr     (i_po_adr),
    .i_po_wr_data (i_po_wr_data),
    .o_h0_ack     (o_h0_ack),
    .o_h1_ack     (o_h1_ack),
    .o_h0_rd_data (o_h0_rd_data),
    .o_h1_rd_data (o_h1_rd_data),
    .o_po_rd_data (o_po_rd_data),
    .bus          (bus)
  );

  trig_ctrl_regs trig0 (
    .clk                (clk),
    .rst                (rst),
    .i_vnum             (i_vnum),
    .i_adc_spi_task_val (adc_spi_task_val),
    .i_adc_spi_wr_data  (o_adc_spi_wr_data),
    .i_wds_used         (wds_used_val),
    .i_scaler           (scaler_val),
    .i_stat_sel         (stat_sel),
    .i_scaler_sel       (scaler_sel),
    .o_trig_ctrl        (o_trig_ctrl),
    .o_trig_thr         (o_trig_thr),
    .o_trig_run         (o_trig_run),
    .bus                (bus)
  );

  spi_task_reg spi0 (
    .clk               (clk),
    .rst               (rst),
    .i_adc_spi_ack     (i_adc_spi_ack),
    .o_adc_spi_req     (o_adc_spi_req),
    .o_task_val        (adc_spi_task_val),
    .o_adc_spi_wr_data (o_adc_spi_wr_data),
    .bus               (bus)
  );

  ////////////////////
  // status selectors
  chan_stat_sel #(
    .payload_t (xdom_pkg::wds_word_t),
    .SEL_ADR   (xdom_pkg::ADR_STAT_SEL)
  ) wds_sel0 (
    .clk         (clk),
    .rst         (rst),
    .i_chan_vals (i_buf_wds_used),
    .o_sel       (stat_sel),
    .o_val       (wds_used_val),
    .bus         (bus)
  );

  chan_stat_sel #(
    .payload_t (xdom_pkg::scaler_word_t),
    .SEL_ADR   (xdom_pkg::ADR_SCALER_SEL)
  ) scaler_sel0 (
    .clk         (clk),
    .rst         (rst),
    .i_chan_vals (i_disc_scaler),
    .o_sel       (scaler_sel),
    .o_val       (scaler_val),
    .bus         (bus)
  );

endmodule

//--- xdom_core_checker.sv
// concurrent assertions on the hub's top-level ports
//   one-cycle acks, acks only on a pending request
//   single-cycle trigger pulse, no new ack under a held override

`timescale 1ns/1ps

module xdom_core_checker (
  input logic                              clk,
  input logic                              rst,
  input logic                              i_h0_wr_req,
  input logic                              i_h0_rd_req,
  input logic                              i_h0_ack,
  input logic                              i_h1_wr_req,
  input logic                              i_h1_rd_req,
  input logic                              i_h1_ack,
  input logic                              i_po_en,
  input logic [xdom_pkg::N_CHANNELS-1:0]   i_trig_run
);

  int   n_fail = 0;
  logic h0_req;
  logic h1_req;

  assign h0_req = i_h0_wr_req | i_h0_rd_req;
  assign h1_req = i_h1_wr_req | i_h1_rd_req;

  ////////////////////
  // host acknowledge
  h0_ack_pulse: assert property (@(posedge clk) disable iff (rst) i_h0_ack |=> !i_h0_ack)
    else begin
      $error("h0 ack held longer than one cycle");
      n_fail++;
    end

  h1_ack_pulse: assert property (@(posedge clk) disable iff (rst) i_h1_ack |=> !i_h1_ack)
    else begin
      $error("h1 ack held longer than one cycle");
      n_fail++;
    end

  // host still requesting in the bus cycle before its ack
  h0_ack_on_req: assert property (@(posedge clk) disable iff (rst) i_h0_ack |-> $past(h0_req))
    else begin
      $error("h0 ack without a request");
      n_fail++;
    end

  h1_ack_on_req: assert property (@(posedge clk) disable iff (rst) i_h1_ack |-> $past(h1_req))
    else begin
      $error("h1 ack without a request");
      n_fail++;
    end

  ////////////////////
  // trigger and override
  trig_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (|i_trig_run) |=> (i_trig_run == '0))
    else begin
      $error("software trigger high two cycles in a row");
      n_fail++;
    end

  // a grant needs the override low at its sampling edge two cycles back
  no_ack_under_po: assert property (@(posedge clk) disable iff (rst)
    (i_h0_ack || i_h1_ack) |-> !($past(i_po_en) && $past(i_po_en, 2)))
    else begin
      $error("host ack while the priority override was held");
      n_fail++;
    end

endmodule

//--- xdom_core_tb.sv
// testbench top for the command, response and status hub
//   host-port tasks and read checks
//   round-robin, override, register, trigger, SPI and status tests
//   error counts and watchdog

`timescale 1ns/1ps

module xdom_core_tb;

  // about 60 host accesses of a few cycles each plus a wide margin
  localparam int WATCHDOG_CYCLES = 2000;
  localparam int N_CH            = xdom_pkg::N_CHANNELS;

  logic clk;
  logic rst;
  logic [1:0]                             wr_req;
  logic [1:0]                             rd_req;
  logic [1:0][xdom_pkg::ADR_W-1:0]        adr;
  logic [1:0][xdom_pkg::DATA_W-1:0]       wr_data;
  logic [1:0]                             ack;
  logic [1:0][xdom_pkg::DATA_W-1:0]       rd_data;
  logic                                   po_en;
  logic                                   po_wr;
  logic [xdom_pkg::ADR_W-1:0]             po_adr;
  logic [xdom_pkg::DATA_W-1:0]            po_wr_data;
  logic [xdom_pkg::DATA_W-1:0]            po_rd_data;
  logic [xdom_pkg::DATA_W-1:0]            vnum;
  logic                                   adc_spi_ack;
  logic                                   adc_spi_req;
  logic [xdom_pkg::SPI_DATA_W-1:0]        adc_spi_wr_data;
  xdom_pkg::trig_ctrl_t                   trig_ctrl;
  logic [xdom_pkg::THR_W-1:0]             trig_thr;
  logic [N_CH-1:0]                        trig_run;
  xdom_pkg::wds_word_t [N_CH-1:0]         wds_used;
  xdom_pkg::scaler_word_t [N_CH-1:0]      scaler;

  integer          seed;
  logic [31:0]     rnd;
  int              n_mismatch;
  int              n_other;
  int              n_trig_pulse;
  logic            last_h1;
  logic [N_CH-1:0] exp_mask;
  int              sel_list [5];
  time             t_po_fall;
  time             t_po_ack;
  logic [xdom_pkg::DATA_W-1:0] po_q;
  xdom_pkg::scaler_word_t      exp_scaler;

  tb_clk_gen clk_gen0 (
    .o_clk (clk),
    .o_rst (rst)
  );

  xdom_core dut0 (
    .clk               (clk),
    .rst               (rst),
    .i_h0_wr_req       (wr_req[0]),
    .i_h0_rd_req       (rd_req[0]),
    .i_h0_adr          (adr[0]),
    .i_h0_wr_data      (wr_data[0]),
    .o_h0_ack          (ack[0]),
    .o_h0_rd_data      (rd_data[0]),
    .i_h1_wr_req       (wr_req[1]),
    .i_h1_rd_req       (rd_req[1]),
    .i_h1_adr          (adr[1]),
    .i_h1_wr_data      (wr_data[1]),
    .o_h1_ack          (ack[1]),
    .o_h1_rd_data      (rd_data[1]),
    .i_po_en           (po_en),
    .i_po_wr           (po_wr),
    .i_po_adr          (po_adr),
    .i_po_wr_data      (po_wr_data),
    .o_po_rd_data      (po_rd_data),
    .i_vnum            (vnum),
    .o_trig_ctrl       (trig_ctrl),
    .o_trig_thr        (trig_thr),
    .o_trig_run        (trig_run),
    .o_adc_spi_req     (adc_spi_req),
    .i_adc_spi_ack     (adc_spi_ack),
    .o_adc_spi_wr_data (adc_spi_wr_data),
    .i_buf_wds_used    (wds_used),
    .i_disc_scaler     (scaler)
  );

  bind xdom_core xdom_core_checker chk0 (
    .clk         (clk),
    .rst         (rst),
    .i_h0_wr_req (i_h0_wr_req),
    .i_h0_rd_req (i_h0_rd_req),
    .i_h0_ack    (o_h0_ack),
    .i_h1_wr_req (i_h1_wr_req),
    .i_h1_rd_req (i_h1_rd_req),
    .i_h1_ack    (o_h1_ack),
    .i_po_en     (i_po_en),
    .i_trig_run  (o_trig_run)
  );

  ////////////////////
  // checks and host tasks
  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      n_mismatch++;
    end
  endtask

  task automatic report_fail(input string msg);
    $display("%s", msg);
    n_other++;
  endtask

  // request held until ack and dropped in the cycle after
  task automatic host_access(input int h, input logic is_wr,
                             input logic [xdom_pkg::ADR_W-1:0] a,
                             input logic [xdom_pkg::DATA_W-1:0] d,
                             output logic [xdom_pkg::DATA_W-1:0] q, output time t_ack);
    @(posedge clk);
    #1;
    adr[h]     = a;
    wr_data[h] = d;
    wr_req[h]  = is_wr;
    rd_req[h]  = !is_wr;
    do begin
      @(posedge clk);
      #1;
    end while (!ack[h]);
    q     = rd_data[h];
    t_ack = $time;
    @(posedge clk);
    #1;
    wr_req[h] = 1'b0;
    rd_req[h] = 1'b0;
  endtask

  task automatic write_reg(input int h, input logic [xdom_pkg::ADR_W-1:0] a,
                           input logic [xdom_pkg::DATA_W-1:0] d);
    logic [xdom_pkg::DATA_W-1:0] q;
    time t;
    host_access(h, 1'b1, a, d, q, t);
    last_h1 = (h == 1);
  endtask

  task automatic read_check(input int h, input logic [xdom_pkg::ADR_W-1:0] a,
                            input logic [xdom_pkg::DATA_W-1:0] exp);
    logic [xdom_pkg::DATA_W-1:0] q;
    time t;
    host_access(h, 1'b0, a, '0, q, t);
    check_eq($sformatf("o_h%0d_rd_data @%h", h, a), q, exp);
    last_h1 = (h == 1);
  endtask

  // both hosts read the version word in the same cycle
  task automatic tie_round();
    logic [xdom_pkg::DATA_W-1:0] q0;
    logic [xdom_pkg::DATA_W-1:0] q1;
    time t0;
    time t1;
    int  first;
    first = last_h1 ? 0 : 1;
    fork
      host_access(0, 1'b0, xdom_pkg::ADR_VNUM, '0, q0, t0);
      host_access(1, 1'b0, xdom_pkg::ADR_VNUM, '0, q1, t1);
    join
    assert ((first == 1) ? (t1 < t0) : (t0 < t1)) else
      report_fail($sformatf("round-robin order wrong, h%0d should have won the tie", first));
    check_eq("o_h0_rd_data @fff", q0, vnum);
    check_eq("o_h1_rd_data @fff", q1, vnum);
    last_h1 = (first == 0);
  endtask

  // trigger pulse only in an ack cycle and equal to the mask
  always @(negedge clk) begin
    if (!rst && (trig_run != '0)) begin
      n_trig_pulse++;
      assert (ack != 2'b00) else report_fail("software trigger outside an ack cycle");
      check_eq("o_trig_run", trig_run, exp_mask);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // main sequence
  initial begin
    wr_req       = '0;
    rd_req       = '0;
    adr          = '0;
    wr_data      = '0;
    po_en        = 1'b0;
    po_wr        = 1'b0;
    po_adr       = '0;
    po_wr_data   = '0;
    vnum         = 16'h3a17;
    adc_spi_ack  = 1'b0;
    n_mismatch   = 0;
    n_other      = 0;
    n_trig_pulse = 0;
    last_h1      = 1'b0;
    exp_mask     = '0;
    sel_list     = '{0, 7, 23, 24, 31};
    seed         = 26;
    for (int i = 0; i < N_CH; i++) begin
      rnd         = $random(seed);
      wds_used[i] = rnd[15:0];
      rnd         = $random(seed);
      scaler[i]   = rnd;
    end
    wait (!rst);

    // h1 wins the first round-robin tie after reset
    tie_round();
    tie_round();
    write_reg(1, xdom_pkg::ADR_TRIG_CTRL, 16'h0000);
    tie_round();

    // write and readback masked to field widths
    write_reg(0, xdom_pkg::ADR_TRIG_CTRL, 16'hfff5);
    write_reg(1, xdom_pkg::ADR_TRIG_THR, 16'hfabc);
    write_reg(0, xdom_pkg::ADR_SW_MASK_HI, 16'h12a5);
    write_reg(1, xdom_pkg::ADR_SW_MASK_LO, 16'h5a3c);
    exp_mask = {8'ha5, 16'h5a3c};
    read_check(1, xdom_pkg::ADR_TRIG_CTRL, 16'h0075);
    read_check(0, xdom_pkg::ADR_TRIG_THR, 16'h0abc);
    read_check(1, xdom_pkg::ADR_SW_MASK_HI, 16'h00a5);
    read_check(0, xdom_pkg::ADR_SW_MASK_LO, 16'h5a3c);
    check_eq("o_trig_thr", trig_thr, 32'h0abc);
    check_eq("o_trig_ctrl", trig_ctrl, 32'h0075);

    // priority override with an h0 read left waiting
    @(posedge clk);
    #1;
    po_en = 1'b1;
    fork
      host_access(0, 1'b0, xdom_pkg::ADR_TRIG_THR, '0, po_q, t_po_ack);
      begin
        @(posedge clk);
        #1;
        po_adr = xdom_pkg::ADR_VNUM;
        @(negedge clk);
        check_eq("o_po_rd_data", po_rd_data, vnum);
        @(posedge clk);
        #1;
        po_adr     = xdom_pkg::ADR_TRIG_THR;
        po_wr_data = 16'h5e71;
        po_wr      = 1'b1;
        @(posedge clk);
        #1;
        po_wr = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        po_en     = 1'b0;
        t_po_fall = $time;
      end
    join
    last_h1 = 1'b0;
    assert (t_po_ack > t_po_fall) else report_fail("h0 ack came while the override was on");
    check_eq("o_h0_rd_data @bfd", po_q, 16'h0e71);

    // software trigger pulse and a write with bit 0 clear
    write_reg(0, xdom_pkg::ADR_TRIG_PULSE, 16'h0001);
    write_reg(1, xdom_pkg::ADR_TRIG_PULSE, 16'h0002);
    assert (n_trig_pulse == 1) else
      report_fail($sformatf("expected one trigger pulse, saw %0d", n_trig_pulse));

    // ADC SPI task
    write_reg(1, xdom_pkg::ADR_ADC_SPI_HI, 16'h77cd);
    write_reg(0, xdom_pkg::ADR_ADC_SPI_LO, 16'h1234);
    write_reg(1, xdom_pkg::ADR_ADC_SPI_TASK, 16'h0001);
    check_eq("o_adc_spi_req", adc_spi_req, 1);
    read_check(0, xdom_pkg::ADR_ADC_SPI_TASK, 16'h0001);
    read_check(1, xdom_pkg::ADR_ADC_SPI_HI, 16'h00cd);
    read_check(0, xdom_pkg::ADR_ADC_SPI_LO, 16'h1234);
    check_eq("o_adc_spi_wr_data", adc_spi_wr_data, 32'h00cd1234);
    @(posedge clk);
    #1;
    adc_spi_ack = 1'b1;
    @(posedge clk);
    #1;
    adc_spi_ack = 1'b0;
    check_eq("o_adc_spi_req", adc_spi_req, 0);
    read_check(1, xdom_pkg::ADR_ADC_SPI_TASK, 16'h0000);

    // per-channel status with out-of-range selects reading zero
    foreach (sel_list[i]) begin
      write_reg(0, xdom_pkg::ADR_STAT_SEL, 16'(sel_list[i]));
      write_reg(1, xdom_pkg::ADR_SCALER_SEL, 16'(sel_list[i]));
      exp_scaler = (sel_list[i] < N_CH) ? scaler[sel_list[i]] : '0;
      read_check(1, xdom_pkg::ADR_STAT_SEL, 16'(sel_list[i]));
      read_check(0, xdom_pkg::ADR_SCALER_SEL, 16'(sel_list[i]));
      read_check(0, xdom_pkg::ADR_WDS_USED,
                 (sel_list[i] < N_CH) ? wds_used[sel_list[i]] : 16'h0000);
      read_check(1, xdom_pkg::ADR_SCALER_HI, exp_scaler[31:16]);
      read_check(0, xdom_pkg::ADR_SCALER_LO, exp_scaler[15:0]);
    end

    repeat (4) @(posedge clk);
    $display("errors: %0d mismatch, %0d other, %0d assertion",
             n_mismatch, n_other, dut0.chk0.n_fail);
    if (n_mismatch + n_other + dut0.chk0.n_fail == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- xdom_pkg.sv
// shared definitions for the command, response and status hub
//   register bus widths, channel count, field widths
//   status payload types and the trigger mode struct
//   register address map

package xdom_pkg;

  localparam int ADR_W      = 12;
  localparam int DATA_W     = 16;
  localparam int N_CHANNELS = 24;
  localparam int CHAN_SEL_W = 5;
  localparam int THR_W      = 12;
  localparam int SPI_DATA_W = 24;

  typedef logic [DATA_W-1:0]   wds_word_t;
  typedef logic [2*DATA_W-1:0] scaler_word_t;

  // trigger mode bits, one bus word
  typedef struct packed {
    logic [DATA_W-8:0] pad;
    logic              ext_en;
    logic              thr_en;
    logic              disc_en;
    logic              disc_pol;
    logic              lt;
    logic              gt;
    logic              et;
  } trig_ctrl_t;

  ////////////////////
  // register map
  localparam logic [ADR_W-1:0] ADR_VNUM         = 12'hfff;
  localparam logic [ADR_W-1:0] ADR_TRIG_CTRL    = 12'hbfe;
  localparam logic [ADR_W-1:0] ADR_TRIG_THR     = 12'hbfd;
  localparam logic [ADR_W-1:0] ADR_SW_MASK_HI   = 12'hbfc;
  localparam logic [ADR_W-1:0] ADR_SW_MASK_LO   = 12'hbfb;
  localparam logic [ADR_W-1:0] ADR_TRIG_PULSE   = 12'hbf8;
  localparam logic [ADR_W-1:0] ADR_STAT_SEL     = 12'hbef;
  localparam logic [ADR_W-1:0] ADR_WDS_USED     = 12'hbed;
  localparam logic [ADR_W-1:0] ADR_ADC_SPI_TASK = 12'hbdb;
  localparam logic [ADR_W-1:0] ADR_ADC_SPI_HI   = 12'hbda;
  localparam logic [ADR_W-1:0] ADR_ADC_SPI_LO   = 12'hbd9;
  localparam logic [ADR_W-1:0] ADR_SCALER_SEL   = 12'hbb8;
  localparam logic [ADR_W-1:0] ADR_SCALER_HI    = 12'hbb7;
  localparam logic [ADR_W-1:0] ADR_SCALER_LO    = 12'hbb6;

endpackage
